//--- verilog.f
+incdir+verilog
+incdir+tb
verilog/capture_pkg.sv
verilog/block_packer.sv
verilog/word_fifo.sv
verilog/dram_burst_writer.sv
verilog/capture_datapath.sv
tb/capture_tb.sv

//--- Makefile
# Verilator build and run of the capture datapath testbench
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= capture_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# Builds, runs, and fails unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/capture_tb_tasks.svh
// Directed tests and their helpers for the capture datapath testbench
// Included in the testbench module body and works on its signals and burst queues
// Expected words and addresses follow the packing and address rules of the design

`ifndef CAPTURE_TB_TASKS_SVH
`define CAPTURE_TB_TASKS_SVH

//////////////////////////////
// Expected values

// 1, pod bit, channel, burst pointer, two zero bits
function automatic capture_pkg::ram_addr_t expected_addr(input int ch, input int ptr);
	return {1'b1, pod[0], capture_pkg::channel_t'(ch), capture_pkg::wr_ptr_t'(ptr), 2'b00};
endfunction

// Seven blocks from index first with the oldest in the highest slot and zero padding
function automatic capture_pkg::word_t expected_word(input int ch, input int first);
	capture_pkg::word_t w;
	w = '0;
	for (int i = 0; i < `BLOCKS_PER_WORD; i++)
		w[(`BLOCKS_PER_WORD-1-i)*`BLOCK_WIDTH +: `BLOCK_WIDTH] = sent[ch][first+i];
	return w;
endfunction

//////////////////////////////
// Compare tasks

task automatic compare_addr(input string name, input capture_pkg::ram_addr_t exp,
		input capture_pkg::ram_addr_t act);
	if (act !== exp) begin
		$display("[ERROR] %s: address expected %h, actual %h", name, exp, act);
		error_count++;
	end
endtask

task automatic compare_word(input string name, input capture_pkg::word_t exp,
		input capture_pkg::word_t act);
	if (act !== exp) begin
		$display("[ERROR] %s: word expected %h, actual %h", name, exp, act);
		error_count++;
	end
endtask

task automatic compare_flags(input string name, input logic [`CHANNEL_COUNT-1:0] exp,
		input logic [`CHANNEL_COUNT-1:0] act);
	if (act !== exp) begin
		$display("[ERROR] %s: overflow expected %b, actual %b", name, exp, act);
		error_count++;
	end
endtask

//////////////////////////////
// Drive and wait

// One block per cycle on each masked channel and only armed blocks are recorded
task automatic send_blocks(input logic [`CHANNEL_COUNT-1:0] mask, input int count);
	capture_pkg::block_t d;
	repeat (count) begin
		@(negedge clk_ram_2x);
		for (int ch = 0; ch < `CHANNEL_COUNT; ch++) begin
			block_valid[ch] = mask[ch];
			if (mask[ch]) begin
				d = capture_pkg::block_t'($random(seed));
				block_data[ch] = d;
				if (ram_ready && sent_count[ch] < 256) begin
					sent[ch][sent_count[ch]] = d;
					sent_count[ch]++;
				end
			end
		end
	end
	@(negedge clk_ram_2x);
	block_valid = '0;
endtask

// Until the monitor holds n_addr requests and n_words words
task automatic wait_for_records(input string name, input int n_addr, input int n_words);
	int cycles;
	cycles = 0;
	while ((addr_q.size() < n_addr || data_q.size() < n_words) && cycles < wait_limit) begin
		@(posedge clk_ram_2x);
		cycles++;
	end
	if (addr_q.size() < n_addr || data_q.size() < n_words) begin
		$display("%s: timed out waiting for DRAM writes", name);
		error_count++;
	end
endtask

task automatic wait_for_overflow(input string name, input int ch);
	int cycles;
	cycles = 0;
	while (!overflow[ch] && cycles < wait_limit) begin
		@(negedge clk_ram_2x);
		cycles++;
	end
	if (!overflow[ch]) begin
		$display("%s: timed out waiting for overflow on channel %0d", name, ch);
		error_count++;
	end
endtask

// Request count after a fixed observation window
task automatic expect_requests(input string name, input int count, input int cycles);
	repeat (cycles) @(posedge clk_ram_2x);
	if (addr_q.size() != count) begin
		$display("[ERROR] %s: request count expected %0d, actual %0d", name, count,
			addr_q.size());
		error_count++;
	end
endtask

// Pops one request and its four words
task automatic check_burst(input string name, input int ch, input int ptr, input int first);
	if (addr_q.size() == 0 || data_q.size() < `BURST_WORDS) begin
		$display("%s: burst for channel %0d was not seen", name, ch);
		error_count++;
		return;
	end
	compare_addr(name, expected_addr(ch, ptr), addr_q.pop_front());
	for (int w = 0; w < `BURST_WORDS; w++)
		compare_word(name, expected_word(ch, first + w * `BLOCKS_PER_WORD), data_q.pop_front());
endtask

task automatic finish_test(input string name);
	tests_run++;
	if (error_count == test_errors)
		$display("Test %s: ok", name);
	else
		$display("Test %s: %0d errors", name, error_count - test_errors);
	test_errors = error_count;
endtask

//////////////////////////////
// Directed tests

task automatic test_reset();
	expect_requests("reset", 0, 50);
	@(negedge clk_ram_2x);
	compare_flags("reset", '0, overflow);
	finish_test("reset");
endtask

task automatic test_one_burst();
	@(negedge clk_ram_2x);
	ram_ready = 1'b1;
	send_blocks(8'h08, 4 * `BLOCKS_PER_WORD);
	wait_for_records("one_burst", 1, `BURST_WORDS);
	check_burst("one_burst", 3, 0, 0);
	finish_test("one_burst");
endtask

task automatic test_pointer_increment();
	send_blocks(8'h08, 4 * `BLOCKS_PER_WORD);
	wait_for_records("pointer_increment", 1, `BURST_WORDS);
	check_burst("pointer_increment", 3, 1, 28);
	finish_test("pointer_increment");
endtask

// Channels 1 and 5 reach a full burst on the same edge
task automatic test_priority();
	@(posedge clk_ram_2x);
	ack_hold = 1'b1;
	send_blocks(8'h22, 4 * `BLOCKS_PER_WORD);
	wait_for_records("priority", 1, 0);
	// Channel 1 waits behind the request that has no ack yet
	expect_requests("priority", 1, 50);
	@(posedge clk_ram_2x);
	ack_hold = 1'b0;
	wait_for_records("priority", 2, 2 * `BURST_WORDS);
	check_burst("priority", 5, 0, 0);
	check_burst("priority", 1, 0, 0);
	finish_test("priority");
endtask

// Disarmed blocks must not count toward the word on channel 2
task automatic test_arm_partial();
	@(negedge clk_ram_2x);
	ram_ready = 1'b0;
	send_blocks(8'h04, 28);
	@(negedge clk_ram_2x);
	ram_ready = 1'b1;
	send_blocks(8'h04, 3 * `BLOCKS_PER_WORD);
	expect_requests("arm_partial", 0, 200);
	send_blocks(8'h04, `BLOCKS_PER_WORD);
	wait_for_records("arm_partial", 1, `BURST_WORDS);
	check_burst("arm_partial", 2, 0, 0);
	finish_test("arm_partial");
endtask

// Writer stalls on channel 6 while its FIFO fills past the depth
task automatic test_overflow();
	@(posedge clk_ram_2x);
	ack_hold = 1'b1;
	send_blocks(8'h40, 33 * `BLOCKS_PER_WORD);
	wait_for_overflow("overflow", 6);
	compare_flags("overflow", 8'h40, overflow);
	finish_test("overflow");
endtask

`endif

//--- tb/capture_tb.sv
// Testbench top for the capture datapath
// Clock, reset, DUT, a DRAM acknowledge model, a burst monitor
// and the directed test sequence from the included task file

`include "capture_defs.svh"

module capture_tb;

	localparam int pod        = 0;
	localparam int wait_limit = 2000;

	logic                                     clk_ram_2x;
	logic                                     reset;
	logic                                     ram_ready;
	logic [`CHANNEL_COUNT-1:0]                block_valid;
	capture_pkg::block_t [`CHANNEL_COUNT-1:0] block_data;
	logic                                     ram_wr_ack;
	logic                                     ram_wr_en;
	capture_pkg::ram_addr_t                   ram_wr_addr;
	capture_pkg::word_t                       ram_wr_data;
	logic [`CHANNEL_COUNT-1:0]                overflow;

	// Ack delay in cycles and a hold that stalls the ack
	int   ack_delay;
	logic ack_hold;

	// Addresses and words seen on the DRAM port
	capture_pkg::ram_addr_t addr_q[$];
	capture_pkg::word_t     data_q[$];

	// Accepted blocks per channel, oldest first
	capture_pkg::block_t sent [`CHANNEL_COUNT][256];
	int                  sent_count [`CHANNEL_COUNT];

	integer seed;
	int     error_count;
	int     test_errors;
	int     tests_run;

	capture_datapath #(
		.pod_number (pod)
	) DUT (
		.clk_ram_2x  (clk_ram_2x),
		.reset       (reset),
		.ram_ready   (ram_ready),
		.block_valid (block_valid),
		.block_data  (block_data),
		.ram_wr_ack  (ram_wr_ack),
		.ram_wr_en   (ram_wr_en),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_data (ram_wr_data),
		.overflow    (overflow)
	);

	// Period of 4
	always #2 clk_ram_2x = ~clk_ram_2x;

	`include "capture_tb_tasks.svh"

	//////////////////////////////
	// DRAM acknowledge model and burst monitor

	// Every request is recorded, also one issued while an ack is pending
	always @(negedge clk_ram_2x) begin
		// Address is valid with the request pulse
		if (ram_wr_en)
			addr_q.push_back(ram_wr_addr);
	end

	initial begin : ram_model
		int waited;
		ram_wr_ack = 1'b0;
		forever begin
			@(negedge clk_ram_2x);
			if (ram_wr_en) begin
				repeat (ack_delay) @(negedge clk_ram_2x);
				// Back-pressure while a test holds the ack back
				waited = 0;
				while (ack_hold && waited < wait_limit) begin
					@(negedge clk_ram_2x);
					waited++;
				end
				if (ack_hold) begin
					$display("RAM model: ack held back longer than %0d cycles", wait_limit);
					error_count++;
				end
				// Ack in cycle A and words in A+2 through A+5
				ram_wr_ack = 1'b1;
				@(negedge clk_ram_2x);
				ram_wr_ack = 1'b0;
				for (int w = 0; w < `BURST_WORDS; w++) begin
					@(negedge clk_ram_2x);
					data_q.push_back(ram_wr_data);
				end
			end
		end
	end

	//////////////////////////////
	// Test sequence

	initial begin
		clk_ram_2x  = 1'b0;
		reset       = 1'b1;
		ram_ready   = 1'b0;
		block_valid = '0;
		block_data  = '0;
		ack_delay   = 2;
		ack_hold    = 1'b0;
		seed        = 32'h4893;
		error_count = 0;
		test_errors = 0;
		tests_run   = 0;
		for (int ch = 0; ch < `CHANNEL_COUNT; ch++)
			sent_count[ch] = 0;
		// Two clock edges in reset
		repeat (2) @(posedge clk_ram_2x);
		@(negedge clk_ram_2x);
		reset = 1'b0;

		test_reset();
		test_one_burst();
		test_pointer_increment();
		test_priority();
		test_arm_partial();
		test_overflow();

		$display("Tests run: %0d, errors: %0d", tests_run, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- verilog/capture_datapath.sv
// RAM-side capture datapath for one logic analyzer pod
// Eight channels of compressed blocks, each packed and buffered per channel
// A single burst writer shares the DRAM write port among the channels
// pod_number bit 0 picks the DRAM region of this pod

`include "capture_defs.svh"

module capture_datapath #(
	parameter int pod_number = 0
) (
	input  logic                                     clk_ram_2x,
	input  logic                                     reset,
	input  logic                                     ram_ready,
	input  logic [`CHANNEL_COUNT-1:0]                block_valid,
	input  capture_pkg::block_t [`CHANNEL_COUNT-1:0] block_data,
	input  logic                                     ram_wr_ack,
	output logic                                     ram_wr_en,
	output capture_pkg::ram_addr_t                   ram_wr_addr,
	output capture_pkg::word_t                       ram_wr_data,
	output logic [`CHANNEL_COUNT-1:0]                overflow
);

	// Packer to FIFO
	logic [`CHANNEL_COUNT-1:0]                pack_wr;
	capture_pkg::word_t [`CHANNEL_COUNT-1:0]  pack_wdata;

	// FIFO to writer
	capture_pkg::word_t [`CHANNEL_COUNT-1:0]       fifo_dout;
	capture_pkg::fifo_level_t [`CHANNEL_COUNT-1:0] fifo_level;
	logic [`CHANNEL_COUNT-1:0]                     fifo_rd;

	//////////////////////////////
	// Per-channel packing and buffering

	for (genvar g = 0; g < `CHANNEL_COUNT; g++) begin : g_channel

		block_packer u_packer (
			.clk_ram_2x  (clk_ram_2x),
			.reset       (reset),
			.ram_ready   (ram_ready),
			.block_valid (block_valid[g]),
			.block_data  (block_data[g]),
			.wr          (pack_wr[g]),
			.wdata       (pack_wdata[g])
		);

		word_fifo u_fifo (
			.clk_ram_2x (clk_ram_2x),
			.reset      (reset),
			.wr         (pack_wr[g]),
			.wdata      (pack_wdata[g]),
			.rd         (fifo_rd[g]),
			.dout       (fifo_dout[g]),
			.level      (fifo_level[g]),
			.overflow   (overflow[g])
		);

	end

	//////////////////////////////
	// Shared DRAM writer

	dram_burst_writer #(
		.pod_number (pod_number)
	) u_writer (
		.clk_ram_2x  (clk_ram_2x),
		.reset       (reset),
		.level       (fifo_level),
		.dout        (fifo_dout),
		.ram_wr_ack  (ram_wr_ack),
		.rd          (fifo_rd),
		.ram_wr_en   (ram_wr_en),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_data (ram_wr_data)
	);

endmodule

//--- verilog/dram_burst_writer.sv
// Drains the per-channel word FIFOs into DRAM in bursts of four words
// Highest-numbered channel holding a full burst wins, only chosen from idle
// One request pulse, then waits for ack with no time limit
// Words follow on ram_wr_data two to five cycles after the ack cycle

`include "capture_defs.svh"

module dram_burst_writer #(
	parameter int pod_number = 0
) (
	input  logic                                          clk_ram_2x,
	input  logic                                          reset,
	input  capture_pkg::fifo_level_t [`CHANNEL_COUNT-1:0] level,
	input  capture_pkg::word_t [`CHANNEL_COUNT-1:0]       dout,
	input  logic                                          ram_wr_ack,
	output logic [`CHANNEL_COUNT-1:0]                     rd,
	output logic                                          ram_wr_en,
	output capture_pkg::ram_addr_t                        ram_wr_addr,
	output capture_pkg::word_t                            ram_wr_data
);

	localparam capture_pkg::fifo_level_t burst_level =
		capture_pkg::fifo_level_t'(`BURST_WORDS);

	// Beat 0 is the ack cycle, reads run through the last read beat
	localparam int beat_width = $clog2(`BURST_WORDS + 2);
	localparam logic [beat_width-1:0] last_read = beat_width'(`BURST_WORDS - 1);
	localparam logic [beat_width-1:0] last_beat = beat_width'(`BURST_WORDS + 1);

	// Selects the upper half of the DRAM region per pod
	localparam logic pod_bit = pod_number[0];

	capture_pkg::writer_state_t state;

	// Channel being served
	capture_pkg::channel_t channel;

	// Arbiter result
	capture_pkg::channel_t pick;
	logic                  pick_valid;

	logic                  rd_en;
	logic [beat_width-1:0] beat;

	// Burst pointer per channel
	capture_pkg::wr_ptr_t wr_ptr [`CHANNEL_COUNT];

	//////////////////////////////
	// Fixed priority arbiter

	// Later iterations override, so the highest ready channel wins
	always_comb begin
		pick       = '0;
		pick_valid = 1'b0;
		for (int i = 0; i < `CHANNEL_COUNT; i++) begin
			if (level[i] >= burst_level) begin
				pick       = capture_pkg::channel_t'(i);
				pick_valid = 1'b1;
			end
		end
	end

	//////////////////////////////
	// FIFO reads

	// First read lands in the ack cycle itself, three more follow
	assign rd_en = ((state == capture_pkg::wait_ack) && ram_wr_ack) ||
		((state == capture_pkg::stream) && (beat <= last_read));

	// One-hot toward the served channel
	assign rd = rd_en ? (`CHANNEL_COUNT'(1) << channel) : '0;

	//////////////////////////////
	// FSM and pointers

	always_ff @(posedge clk_ram_2x) begin
		ram_wr_en <= 1'b0;
		if (reset) begin
			state   <= capture_pkg::idle;
			channel <= '0;
			beat    <= '0;
			for (int i = 0; i < `CHANNEL_COUNT; i++)
				wr_ptr[i] <= '0;
		end else begin
			case (state)
				capture_pkg::idle: begin
					if (pick_valid) begin
						channel <= pick;
						state   <= capture_pkg::request;
					end
				end
				// Single request pulse, bump pointer for the next burst
				capture_pkg::request: begin
					ram_wr_en       <= 1'b1;
					wr_ptr[channel] <= wr_ptr[channel] + 1'b1;
					state           <= capture_pkg::wait_ack;
				end
				// RAM back-pressure, hold here as long as needed
				capture_pkg::wait_ack: begin
					if (ram_wr_ack) begin
						beat  <= beat_width'(1);
						state <= capture_pkg::stream;
					end
				end
				capture_pkg::stream: begin
					beat <= beat + 1'b1;
					// Last word is on the bus this cycle
					if (beat == last_beat)
						state <= capture_pkg::idle;
				end
				default: state <= capture_pkg::idle;
			endcase
		end
	end

	//////////////////////////////
	// Address and data

	always_ff @(posedge clk_ram_2x) begin
		// Data mux registered every cycle, qualified by timing only
		ram_wr_data <= dout[channel];
		// 1, pod, channel, pointer, word within burst
		if (state == capture_pkg::request)
			ram_wr_addr <= {1'b1, pod_bit, channel, wr_ptr[channel], 2'b00};
	end

endmodule

//--- verilog/word_fifo.sv
// Single-clock word buffer between a block packer and the burst writer
// 32 entries, registered read data valid the cycle after rd
// level counts stored words; writes into a full buffer are dropped
// overflow stays set from the first dropped write until reset

`include "capture_defs.svh"

module word_fifo (
	input  logic                     clk_ram_2x,
	input  logic                     reset,
	input  logic                     wr,
	input  capture_pkg::word_t       wdata,
	input  logic                     rd,
	output capture_pkg::word_t       dout,
	output capture_pkg::fifo_level_t level,
	output logic                     overflow
);

	localparam int addr_width = $clog2(`FIFO_DEPTH);
	localparam capture_pkg::fifo_level_t full_level = capture_pkg::fifo_level_t'(`FIFO_DEPTH);

	// Storage
	capture_pkg::word_t mem [`FIFO_DEPTH];

	// Circular pointers, wrap naturally at the depth
	logic [addr_width-1:0] wr_ptr;
	logic [addr_width-1:0] rd_ptr;

	logic full;
	logic empty;
	logic do_wr;
	logic do_rd;

	assign full  = (level == full_level);
	assign empty = (level == '0);

	// Accepted operations
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	//////////////////////////////
	// Memory and output register

	always_ff @(posedge clk_ram_2x) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
		if (do_rd)
			dout <= mem[rd_ptr];
	end

	//////////////////////////////
	// Pointers, level, overflow

	always_ff @(posedge clk_ram_2x) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			level    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous read and write leaves the level alone
			case ({do_wr, do_rd})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
			// Sticky, cleared only by reset
			if (wr && full)
				overflow <= 1'b1;
		end
	end

endmodule

//--- verilog/block_packer.sv
// Packs compressed blocks of one channel into 128-bit words
// Seven blocks per word, oldest in the highest slot, top 9 bits zero
// Blocks only count while the RAM side is ready (armed)
// Emits a one-cycle registered write toward the word FIFO

`include "capture_defs.svh"

module block_packer (
	input  logic                clk_ram_2x,
	input  logic                reset,
	input  logic                ram_ready,
	input  logic                block_valid,
	input  capture_pkg::block_t block_data,
	output logic                wr,
	output capture_pkg::word_t  wdata
);

	localparam int count_width = $clog2(`BLOCKS_PER_WORD);
	localparam int pad_width   = `WORD_WIDTH - `BLOCKS_PER_WORD * `BLOCK_WIDTH;

	// Index of the block that completes a word
	localparam logic [count_width-1:0] last_block = count_width'(`BLOCKS_PER_WORD - 1);

	// Blocks already collected for the current word
	logic [count_width-1:0] count;

	// Newest block at index 0, oldest moves up
	capture_pkg::block_t [`BLOCKS_PER_WORD-2:0] held;

	logic take;

	// Arm gate
	assign take = block_valid && ram_ready;

	//////////////////////////////
	// Control

	always_ff @(posedge clk_ram_2x) begin
		wr <= 1'b0;
		if (reset) begin
			count <= '0;
		end else if (take) begin
			if (count == last_block) begin
				// Word complete, push it next cycle
				wr    <= 1'b1;
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Payload

	always_ff @(posedge clk_ram_2x) begin
		if (take) begin
			held <= {held[`BLOCKS_PER_WORD-3:0], block_data};
			// Seventh block goes straight into the low slot
			if (count == last_block)
				wdata <= {{pad_width{1'b0}}, held, block_data};
		end
	end

endmodule

//--- verilog/capture_pkg.sv
// Shared types for the capture datapath
// Vector typedefs for the meaningful widths and the burst writer FSM encoding
// Modules refer to these by scoped name

`include "capture_defs.svh"

package capture_pkg;

	// One compressed block from a channel
	typedef logic [`BLOCK_WIDTH-1:0] block_t;

	// One packed DRAM word
	typedef logic [`WORD_WIDTH-1:0] word_t;

	// Word FIFO fill count, holds 0 up to FIFO_DEPTH inclusive
	typedef logic [`FIFO_LEVEL_WIDTH-1:0] fifo_level_t;

	// Channel index
	typedef logic [$clog2(`CHANNEL_COUNT)-1:0] channel_t;

	// Per-channel burst pointer, counts 512-bit bursts
	typedef logic [`WR_PTR_WIDTH-1:0] wr_ptr_t;

	// DRAM address in 128-bit words
	typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

	// Burst writer FSM
	typedef enum logic [1:0] {
		idle,
		request,
		wait_ack,
		stream
	} writer_state_t;

endpackage

//--- verilog/capture_defs.svh
// Width, count and depth constants for the capture datapath
// Included by the package and by every RTL module that sizes a port or a counter
// All values are for eight channels of 17-bit compressed blocks

`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// Capture channels per pod
`define CHANNEL_COUNT 8

// One compressed block, format bit plus 16 data bits
`define BLOCK_WIDTH 17

// Blocks packed into one DRAM word, top bits left as padding
`define BLOCKS_PER_WORD 7
`define WORD_WIDTH 128

// Per-channel word buffer
`define FIFO_DEPTH 32
`define FIFO_LEVEL_WIDTH 6

// Words per DRAM write burst
`define BURST_WORDS 4

// Burst pointer per channel and the full DRAM word address
`define WR_PTR_WIDTH 22
`define RAM_ADDR_WIDTH 29

`endif
